// File: logic/keyboard_defines.svh
// ##############################
// ps2 keyboard constants
// ##############################

`ifndef KEYBOARD_DEFINES_SVH
`define KEYBOARD_DEFINES_SVH

// start, eight data, odd parity, stop
`define PS2_FRAME_BITS 11

// flops per input synchroniser
`define PS2_SYNC_STAGES 2

// tracked keys
`define KEY_COUNT 10

// scan code set 2 prefixes
`define SCAN_PREFIX_EXTEND 8'hE0
`define SCAN_PREFIX_BREAK 8'hF0

// plain codes
`define SCAN_CODE_W 8'h1D
`define SCAN_CODE_A 8'h1C
`define SCAN_CODE_S 8'h1B
`define SCAN_CODE_D 8'h23
`define SCAN_CODE_SPACE 8'h29
`define SCAN_CODE_ENTER 8'h5A

// codes sent after the E0 prefix
`define SCAN_CODE_LEFT 8'h6B
`define SCAN_CODE_RIGHT 8'h74
`define SCAN_CODE_UP 8'h75
`define SCAN_CODE_DOWN 8'h72

`endif

// File: logic/keyboard_pkg.sv
// ##############################
// keyboard tracker types
// ##############################

`include "keyboard_defines.svh"

package keyboard_pkg;

  // one received byte, valid is a single-cycle strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } ps2_byte_t;

  // key numbering, also the bit position in key_set_t
  typedef enum logic [$clog2(`KEY_COUNT)-1:0] {
    KEY_W     = 4'd0,
    KEY_A     = 4'd1,
    KEY_S     = 4'd2,
    KEY_D     = 4'd3,
    KEY_LEFT  = 4'd4,
    KEY_RIGHT = 4'd5,
    KEY_UP    = 4'd6,
    KEY_DOWN  = 4'd7,
    KEY_SPACE = 4'd8,
    KEY_ENTER = 4'd9
  } key_index_e;

  // press or release of one key
  typedef struct packed {
    logic       valid;
    key_index_e key;
    logic       pressed;
  } key_event_t;

  // one bit per key, w sits at bit 0 so the enum value indexes it
  typedef struct packed {
    logic enter;
    logic space;
    logic down;
    logic up;
    logic right;
    logic left;
    logic d;
    logic s;
    logic a;
    logic w;
  } key_set_t;

  // what the next key code means
  typedef enum logic [1:0] {
    DECODE_MAKE      = 2'b00,
    DECODE_BREAK     = 2'b01,
    DECODE_EXT_MAKE  = 2'b10,
    DECODE_EXT_BREAK = 2'b11
  } decode_state_e;

endpackage

// File: logic/ps2_receiver.sv
// ##############################
// ps2 frame receiver
// ##############################

`include "keyboard_defines.svh"

module ps2_receiver (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    ps2_clock,
  input  logic                    ps2_data,
  output keyboard_pkg::ps2_byte_t rx_byte,
  output logic                    frame_error
);

  localparam int COUNT_BITS = $clog2(`PS2_FRAME_BITS);

  // synchroniser chains, msb is the settled value
  logic [`PS2_SYNC_STAGES-1:0] clock_sync;
  logic [`PS2_SYNC_STAGES-1:0] data_sync;

  // edge detect on the synchronised keyboard clock
  logic clock_prev;
  logic clock_fall;
  logic data_bit;

  // frame assembly
  logic [COUNT_BITS-1:0]      bit_count;
  logic                       last_bit;
  // the ten most recent bits, the oldest drops out
  logic [`PS2_FRAME_BITS-2:0] frame;
  logic [`PS2_FRAME_BITS-1:0] frame_next;

  // frame checks
  logic start_ok;
  logic stop_ok;
  logic parity_ok;
  logic frame_ok;

  // registered byte output
  logic       rx_valid;
  logic [7:0] rx_data;

  // both lines idle high, so the chains reset to ones
  // and no false falling edge shows up after reset
  always_ff @(posedge clock) begin
    if (!reset) begin
      clock_sync <= '1;
      data_sync  <= '1;
      clock_prev <= 1'b1;
    end else begin
      clock_sync <= {clock_sync[`PS2_SYNC_STAGES-2:0], ps2_clock};
      data_sync  <= {data_sync[`PS2_SYNC_STAGES-2:0], ps2_data};
      clock_prev <= clock_sync[`PS2_SYNC_STAGES-1];
    end
  end

  // keyboard changes data on rising edge, host samples on falling
  assign clock_fall = clock_prev & ~clock_sync[`PS2_SYNC_STAGES-1];
  assign data_bit   = data_sync[`PS2_SYNC_STAGES-1];

  // lsb first on the wire, so new bits enter at the top
  assign frame_next = {data_bit, frame};
  assign last_bit   = (bit_count == COUNT_BITS'(`PS2_FRAME_BITS - 1));

  // bit position within the frame
  always_ff @(posedge clock) begin
    if (!reset) begin
      bit_count <= '0;
    end else if (clock_fall) begin
      if (last_bit) begin
        bit_count <= '0;
      end else begin
        bit_count <= bit_count + COUNT_BITS'(1);
      end
    end
  end

  // shift register, contents only matter once the count is full
  always_ff @(posedge clock) begin
    if (clock_fall) begin
      frame <= frame_next[`PS2_FRAME_BITS-1:1];
    end
  end

  // bit 0 start, 8:1 data, 9 parity, 10 stop
  assign start_ok  = ~frame_next[0];
  assign stop_ok   = frame_next[`PS2_FRAME_BITS-1];
  // odd parity over data plus parity bit
  assign parity_ok = ^frame_next[9:1];
  assign frame_ok  = start_ok & stop_ok & parity_ok;

  // strobes one cycle after the stop-bit edge
  always_ff @(posedge clock) begin
    if (!reset) begin
      rx_valid    <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      rx_valid    <= clock_fall & last_bit & frame_ok;
      frame_error <= clock_fall & last_bit & ~frame_ok;
    end
  end

  // data byte held until the next frame completes
  always_ff @(posedge clock) begin
    if (clock_fall && last_bit) begin
      rx_data <= frame_next[8:1];
    end
  end

  always_comb begin
    rx_byte.valid = rx_valid;
    rx_byte.data  = rx_data;
  end

  // a completed frame is either a byte or an error
  valid_error_exclusive : assert property (
    @(posedge clock) disable iff (!reset)
      !(rx_byte.valid && frame_error)
  );

endmodule

// File: logic/scan_code_decoder.sv
// ##############################
// scan code set 2 decoder
// ##############################

`include "keyboard_defines.svh"

module scan_code_decoder (
  input  logic                     clock,
  input  logic                     reset,
  input  keyboard_pkg::ps2_byte_t  rx_byte,
  output keyboard_pkg::key_event_t key_event
);

  keyboard_pkg::decode_state_e state;

  // decoded view of the current state
  logic extended;
  logic make;

  // code lookup result for the incoming byte
  logic                     code_match;
  keyboard_pkg::key_index_e code_key;

  // registered event
  logic                     event_valid;
  keyboard_pkg::key_index_e event_key;
  logic                     event_pressed;

  assign extended = (state == keyboard_pkg::DECODE_EXT_MAKE) ||
                    (state == keyboard_pkg::DECODE_EXT_BREAK);
  assign make     = (state == keyboard_pkg::DECODE_MAKE) ||
                    (state == keyboard_pkg::DECODE_EXT_MAKE);

  // extended flag is part of the match so 74 and E0 74 stay apart
  always_comb begin
    code_match = 1'b1;
    code_key   = keyboard_pkg::KEY_W;
    case ({extended, rx_byte.data})
      {1'b0, `SCAN_CODE_W}:     code_key = keyboard_pkg::KEY_W;
      {1'b0, `SCAN_CODE_A}:     code_key = keyboard_pkg::KEY_A;
      {1'b0, `SCAN_CODE_S}:     code_key = keyboard_pkg::KEY_S;
      {1'b0, `SCAN_CODE_D}:     code_key = keyboard_pkg::KEY_D;
      {1'b0, `SCAN_CODE_SPACE}: code_key = keyboard_pkg::KEY_SPACE;
      {1'b0, `SCAN_CODE_ENTER}: code_key = keyboard_pkg::KEY_ENTER;
      {1'b1, `SCAN_CODE_LEFT}:  code_key = keyboard_pkg::KEY_LEFT;
      {1'b1, `SCAN_CODE_RIGHT}: code_key = keyboard_pkg::KEY_RIGHT;
      {1'b1, `SCAN_CODE_UP}:    code_key = keyboard_pkg::KEY_UP;
      {1'b1, `SCAN_CODE_DOWN}:  code_key = keyboard_pkg::KEY_DOWN;
      // untracked or wrong prefix
      default:                  code_match = 1'b0;
    endcase
  end

  // prefixes steer the state, anything else ends the sequence
  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= keyboard_pkg::DECODE_MAKE;
    end else if (rx_byte.valid) begin
      if (rx_byte.data == `SCAN_PREFIX_EXTEND) begin
        state <= keyboard_pkg::DECODE_EXT_MAKE;
      end else if (rx_byte.data == `SCAN_PREFIX_BREAK) begin
        // F0 keeps the extended flag of an earlier E0
        state <= extended ? keyboard_pkg::DECODE_EXT_BREAK : keyboard_pkg::DECODE_BREAK;
      end else begin
        state <= keyboard_pkg::DECODE_MAKE;
      end
    end
  end

  // prefix bytes never match a key code, so they raise no event
  always_ff @(posedge clock) begin
    if (!reset) begin
      event_valid <= 1'b0;
    end else begin
      event_valid <= rx_byte.valid & code_match;
    end
  end

  always_ff @(posedge clock) begin
    if (rx_byte.valid) begin
      event_key     <= code_key;
      event_pressed <= make;
    end
  end

  always_comb begin
    key_event.valid   = event_valid;
    key_event.key     = event_key;
    key_event.pressed = event_pressed;
  end

  // downstream indexes a ten bit vector with this
  event_key_in_range : assert property (
    @(posedge clock) disable iff (!reset)
      key_event.valid |-> (int'(key_event.key) < `KEY_COUNT)
  );

endmodule

// File: logic/key_state_tracker.sv
// ##############################
// per-key pressed state
// ##############################

module key_state_tracker (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     pulse_mode,
  input  keyboard_pkg::key_event_t key_event,
  output keyboard_pkg::key_set_t   keys
);

  localparam int KEY_BITS = $bits(keyboard_pkg::key_set_t);

  // live keyboard state, one bit per key
  logic [KEY_BITS-1:0] pressed;
  // pressed one cycle late
  logic [KEY_BITS-1:0] locked;
  logic [KEY_BITS-1:0] keys_vec;

  // only the addressed key moves
  always_ff @(posedge clock) begin
    if (!reset) begin
      pressed <= '0;
    end else if (key_event.valid) begin
      pressed[key_event.key] <= key_event.pressed;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      locked <= '0;
    end else begin
      locked <= pressed;
    end
  end

  // pulse mode keeps only the first cycle of a press
  // a repeated make leaves pressed at one, so no new pulse
  assign keys_vec = pulse_mode ? (pressed & ~locked) : pressed;
  assign keys     = keyboard_pkg::key_set_t'(keys_vec);

  // each press gives a single-cycle pulse
  pulse_single_cycle : assert property (
    @(posedge clock) disable iff (!reset)
      (pulse_mode && (keys_vec != '0)) |=> ((keys_vec & $past(keys_vec)) == '0)
  );

endmodule

// File: logic/keyboard_tracker.sv
// ##############################
// ps2 keyboard key tracker
// ##############################

module keyboard_tracker (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   ps2_clock,
  input  logic                   ps2_data,
  // only changed while reset is low
  input  logic                   pulse_mode,
  output keyboard_pkg::key_set_t keys,
  output logic                   frame_error
);

  // byte stream from the line receiver
  keyboard_pkg::ps2_byte_t  rx_byte;
  // press and release events
  keyboard_pkg::key_event_t key_event;

  // pins to bytes, 3 cycles after the stop-bit edge
  ps2_receiver receiver_i (
    .clock       (clock),
    .reset       (reset),
    .ps2_clock   (ps2_clock),
    .ps2_data    (ps2_data),
    .rx_byte     (rx_byte),
    .frame_error (frame_error)
  );

  // bytes to key events, one more cycle
  scan_code_decoder decoder_i (
    .clock     (clock),
    .reset     (reset),
    .rx_byte   (rx_byte),
    .key_event (key_event)
  );

  // events to hold or pulse outputs
  key_state_tracker tracker_i (
    .clock      (clock),
    .reset      (reset),
    .pulse_mode (pulse_mode),
    .key_event  (key_event),
    .keys       (keys)
  );

endmodule

// File: verification/keyboard_monitor.sv
// ##############################
// keyboard tracker checker
// ##############################

module keyboard_monitor (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   pulse_mode,
  input  keyboard_pkg::key_set_t keys,
  input  logic                   frame_error,
  // one-cycle strobe at the stop-bit falling edge
  input  logic                   check_request,
  input  keyboard_pkg::key_set_t expected_keys,
  input  logic                   expected_error,
  output int                     error_count,
  output int                     check_count
);
  timeunit 1ns;
  timeprecision 1ps;

  // compare point, counted from the stop-bit edge at the pins
  localparam int check_delay = 12;

  int errors = 0;
  int checks = 0;
  int countdown;
  // activity seen since the previous compare
  int error_pulses;
  int key_pulses;
  logic [9:0] pulse_seen;
  // held keys after the previous row
  logic [9:0] previous_keys;

  assign error_count = errors;
  assign check_count = checks;

  task automatic compare_row();
    logic [9:0] new_presses;
    logic [9:0] expected_now;
    checks++;
    // a press is a key that was up before this row
    new_presses  = expected_keys & ~previous_keys;
    // pulses are long gone by the compare point
    expected_now = pulse_mode ? 10'b0 : expected_keys;
    if (keys !== expected_now) begin
      errors++;
      $display("Fail time=%0t signal=keys expected=%b actual=%b", $time, expected_now, keys);
    end
    if (error_pulses != int'(expected_error)) begin
      errors++;
      $display("Fail time=%0t signal=frame_error pulses expected=%0d actual=%0d",
               $time, int'(expected_error), error_pulses);
    end
    if (pulse_mode) begin
      if (pulse_seen !== new_presses) begin
        errors++;
        $display("Fail time=%0t signal=keys pulsed expected=%b actual=%b",
                 $time, new_presses, pulse_seen);
      end
      // each press exactly one cycle high
      if (key_pulses != $countones(new_presses)) begin
        errors++;
        $display("Fail time=%0t signal=keys pulse cycles expected=%0d actual=%0d",
                 $time, $countones(new_presses), key_pulses);
      end
    end
    previous_keys = expected_keys;
    error_pulses  = 0;
    key_pulses    = 0;
    pulse_seen    = '0;
  endtask

  always @(posedge clock) begin
    if (!reset) begin
      countdown     = 0;
      error_pulses  = 0;
      key_pulses    = 0;
      pulse_seen    = '0;
      previous_keys = '0;
    end else begin
      error_pulses = error_pulses + int'(frame_error);
      if (pulse_mode) begin
        key_pulses = key_pulses + $countones(keys);
        pulse_seen = pulse_seen | keys;
      end
      // request seen one cycle after the stop-bit edge
      if (check_request) begin
        countdown = check_delay - 1;
      end else if (countdown > 0) begin
        countdown--;
        if (countdown == 0) begin
          compare_row();
        end
      end
    end
  end

endmodule

// File: verification/keyboard_tracker_tb.sv
// ##############################
// keyboard tracker testbench
// ##############################

`include "keyboard_defines.svh"

module keyboard_tracker_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clock_period    = 40;
  localparam int reset_cycles    = 16;
  localparam int half_bit_cycles = 8;
  localparam int settle_cycles   = 16;
  localparam int cycles_per_row  = 500;

  // bit positions of key_set_t
  localparam logic [9:0] key_w     = 10'h001;
  localparam logic [9:0] key_a     = 10'h002;
  localparam logic [9:0] key_s     = 10'h004;
  localparam logic [9:0] key_d     = 10'h008;
  localparam logic [9:0] key_left  = 10'h010;
  localparam logic [9:0] key_right = 10'h020;
  localparam logic [9:0] key_up    = 10'h040;
  localparam logic [9:0] key_down  = 10'h080;
  localparam logic [9:0] key_space = 10'h100;
  localparam logic [9:0] key_enter = 10'h200;

  // byte on the wire, parity flip, held keys after it, error strobe
  typedef struct packed {
    logic [7:0]             code;
    logic                   corrupt;
    keyboard_pkg::key_set_t keys;
    logic                   error;
  } stim_row_t;

  stim_row_t rows[$];

  logic                   clock;
  logic                   reset;
  logic                   ps2_clock;
  logic                   ps2_data;
  logic                   pulse_mode;
  logic                   check_request;
  keyboard_pkg::key_set_t expected_keys;
  logic                   expected_error;
  keyboard_pkg::key_set_t keys;
  logic                   frame_error;
  int                     error_count;
  int                     check_count;
  int                     expected_checks;
  logic [31:0]            rng_state;

  keyboard_tracker dut_i (
    .clock       (clock),
    .reset       (reset),
    .ps2_clock   (ps2_clock),
    .ps2_data    (ps2_data),
    .pulse_mode  (pulse_mode),
    .keys        (keys),
    .frame_error (frame_error)
  );

  keyboard_monitor monitor_i (
    .clock          (clock),
    .reset          (reset),
    .pulse_mode     (pulse_mode),
    .keys           (keys),
    .frame_error    (frame_error),
    .check_request  (check_request),
    .expected_keys  (expected_keys),
    .expected_error (expected_error),
    .error_count    (error_count),
    .check_count    (check_count)
  );

  always #(clock_period / 2) clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] value);
    logic [31:0] x;
    x = value;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // inputs move 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic add_row(input logic [7:0] code, input logic corrupt,
                         input logic [9:0] held, input logic error);
    stim_row_t row;
    row.code    = code;
    row.corrupt = corrupt;
    row.keys    = keyboard_pkg::key_set_t'(held);
    row.error   = error;
    rows.push_back(row);
  endtask

  task automatic build_table();
    // plain make and break
    add_row(`SCAN_CODE_W, 1'b0, key_w, 1'b0);
    add_row(`SCAN_PREFIX_BREAK, 1'b0, key_w, 1'b0);
    add_row(`SCAN_CODE_W, 1'b0, 10'h000, 1'b0);
    add_row(`SCAN_CODE_A, 1'b0, key_a, 1'b0);
    add_row(`SCAN_PREFIX_BREAK, 1'b0, key_a, 1'b0);
    add_row(`SCAN_CODE_A, 1'b0, 10'h000, 1'b0);
    // several held, released one at a time
    add_row(`SCAN_CODE_S, 1'b0, key_s, 1'b0);
    add_row(`SCAN_CODE_D, 1'b0, key_s | key_d, 1'b0);
    add_row(`SCAN_CODE_SPACE, 1'b0, key_s | key_d | key_space, 1'b0);
    add_row(`SCAN_CODE_ENTER, 1'b0, key_s | key_d | key_space | key_enter, 1'b0);
    add_row(`SCAN_PREFIX_BREAK, 1'b0, key_s | key_d | key_space | key_enter, 1'b0);
    add_row(`SCAN_CODE_S, 1'b0, key_d | key_space | key_enter, 1'b0);
    add_row(`SCAN_PREFIX_BREAK, 1'b0, key_d | key_space | key_enter, 1'b0);
    add_row(`SCAN_CODE_D, 1'b0, key_space | key_enter, 1'b0);
    add_row(`SCAN_PREFIX_BREAK, 1'b0, key_space | key_enter, 1'b0);
    add_row(`SCAN_CODE_SPACE, 1'b0, key_enter, 1'b0);
    add_row(`SCAN_PREFIX_BREAK, 1'b0, key_enter, 1'b0);
    add_row(`SCAN_CODE_ENTER, 1'b0, 10'h000, 1'b0);
    // extended right, then a bare 74 with right up must not alias
    add_row(`SCAN_PREFIX_EXTEND, 1'b0, 10'h000, 1'b0);
    add_row(`SCAN_CODE_RIGHT, 1'b0, key_right, 1'b0);
    add_row(`SCAN_PREFIX_EXTEND, 1'b0, key_right, 1'b0);
    add_row(`SCAN_PREFIX_BREAK, 1'b0, key_right, 1'b0);
    add_row(`SCAN_CODE_RIGHT, 1'b0, 10'h000, 1'b0);
    add_row(`SCAN_CODE_RIGHT, 1'b0, 10'h000, 1'b0);
    // remaining arrows
    add_row(`SCAN_PREFIX_EXTEND, 1'b0, 10'h000, 1'b0);
    add_row(`SCAN_CODE_LEFT, 1'b0, key_left, 1'b0);
    add_row(`SCAN_PREFIX_EXTEND, 1'b0, key_left, 1'b0);
    add_row(`SCAN_CODE_UP, 1'b0, key_left | key_up, 1'b0);
    add_row(`SCAN_PREFIX_EXTEND, 1'b0, key_left | key_up, 1'b0);
    add_row(`SCAN_CODE_DOWN, 1'b0, key_left | key_up | key_down, 1'b0);
    add_row(`SCAN_PREFIX_EXTEND, 1'b0, key_left | key_up | key_down, 1'b0);
    add_row(`SCAN_PREFIX_BREAK, 1'b0, key_left | key_up | key_down, 1'b0);
    add_row(`SCAN_CODE_UP, 1'b0, key_left | key_down, 1'b0);
    // bad parity, then the same byte clean, then a repeat make
    add_row(`SCAN_CODE_W, 1'b1, key_left | key_down, 1'b1);
    add_row(`SCAN_CODE_W, 1'b0, key_left | key_down | key_w, 1'b0);
    add_row(`SCAN_CODE_W, 1'b0, key_left | key_down | key_w, 1'b0);
    // left in break state with keys held when reset hits
    add_row(`SCAN_PREFIX_BREAK, 1'b0, key_left | key_down | key_w, 1'b0);
  endtask

  // low then high, data and clock pass through equal synchronisers
  task automatic drive_bit(input logic value, input logic last);
    ps2_data      = value;
    ps2_clock     = 1'b0;
    check_request = last;
    next_cycle();
    check_request = 1'b0;
    repeat (half_bit_cycles - 1) next_cycle();
    ps2_clock = 1'b1;
    repeat (half_bit_cycles) next_cycle();
  endtask

  task automatic send_frame(input logic [7:0] code, input logic corrupt);
    logic [`PS2_FRAME_BITS-1:0] bits;
    logic                       parity;
    int                         i;
    // odd parity, flipped for a bad frame
    parity = ~(^code) ^ corrupt;
    bits   = {1'b1, parity, code, 1'b0};
    for (i = 0; i < `PS2_FRAME_BITS; i++) begin
      drive_bit(bits[i], i == `PS2_FRAME_BITS - 1);
    end
    ps2_data = 1'b1;
  endtask

  // mode only changes while reset is low
  task automatic apply_reset(input logic mode);
    reset      = 1'b0;
    pulse_mode = mode;
    repeat (reset_cycles) next_cycle();
    reset = 1'b1;
  endtask

  // all keys low straight after reset
  task automatic check_after_reset();
    expected_keys  = '0;
    expected_error = 1'b0;
    check_request  = 1'b1;
    next_cycle();
    check_request = 1'b0;
    repeat (settle_cycles) next_cycle();
    expected_checks++;
  endtask

  initial begin
    int        gap;
    int        pass;
    stim_row_t row;
    clock           = 1'b0;
    reset           = 1'b0;
    ps2_clock       = 1'b1;
    ps2_data        = 1'b1;
    pulse_mode      = 1'b0;
    check_request   = 1'b0;
    expected_keys   = '0;
    expected_error  = 1'b0;
    expected_checks = 0;
    rng_state       = 32'd28;
    build_table();
    next_cycle();
    for (pass = 0; pass < 2; pass++) begin
      apply_reset(pass == 1);
      check_after_reset();
      foreach (rows[i]) begin
        row            = rows[i];
        expected_keys  = row.keys;
        expected_error = row.error;
        send_frame(row.code, row.corrupt);
        expected_checks++;
        rng_state = xorshift(rng_state);
        // idle gap of 20 to 35 cycles
        gap = 20 + int'(rng_state % 32'd16);
        repeat (gap) next_cycle();
      end
    end
    repeat (settle_cycles) next_cycle();
    if (check_count != expected_checks) begin
      $display("only %0d of %0d expected checks were made", check_count, expected_checks);
    end
    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0 && check_count == expected_checks) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // limit grows with the table length
  initial begin
    longint limit;
    #1;
    limit = (longint'(rows.size()) * 2 * cycles_per_row
             + 2 * (reset_cycles + settle_cycles)) * clock_period;
    #(limit);
    $display("timeout, stimulus did not finish within %0d ns", limit);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: project.f
+incdir+logic
logic/keyboard_pkg.sv
logic/ps2_receiver.sv
logic/scan_code_decoder.sv
logic/key_state_tracker.sv
logic/keyboard_tracker.sv
verification/keyboard_monitor.sv
verification/keyboard_tracker_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the PS/2 keyboard tracker

RTL_FILES = logic/keyboard_pkg.sv logic/ps2_receiver.sv logic/scan_code_decoder.sv \
            logic/key_state_tracker.sv logic/keyboard_tracker.sv

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 -f project.f --top-module keyboard_tracker_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vkeyboard_tracker_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

lint:
	verilator --lint-only -Wall -Ilogic $(RTL_FILES) --top-module keyboard_tracker

clean:
	rm -rf obj_dir
